// File: source/cab_bus_pkg.sv
package cab_bus_pkg;

  // master byte address
  typedef logic [15:0] addr_t;

  // one data word as seen by a master
  typedef logic [31:0] data_t;

  // one word on the slave request and acknowledge channels
  typedef logic [15:0] half_t;

  // slave request word read either as a header or as raw write data
  typedef union packed {
    struct packed {
      logic [13:0] offset;
      logic        rsvd;
      logic        wr;
    } hdr;
    half_t data;
  } sreq_word_u;

  // request serializer states
  typedef enum logic [1:0] {
    send_addr,
    send_wdata_lo,
    send_wdata_hi
  } send_state_t;

endpackage

// File: source/cab_map_pkg.sv
package cab_map_pkg;

  // slave j owns CAB_WINDOW bytes starting at j * CAB_WINDOW
  localparam int CAB_WINDOW = 4096;

  // header carries the word offset, so the byte offset is shifted by this
  localparam int HDR_OFS_LSB = 2;

  // 1 ms at 250 MHz
  localparam int DEFAULT_TIMEOUT = 250000;

endpackage

// File: source/cab_req_decode.sv
`timescale 1ns/1ns

module cab_req_decode #(
  parameter int MST_CNT = 2,
  parameter int SLV_CNT = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  cab_bus_pkg::addr_t maddr [MST_CNT],
  input  cab_bus_pkg::data_t mwdata [MST_CNT],
  input  logic [MST_CNT-1:0] mwr,
  input  logic [MST_CNT-1:0] mreq,
  input  logic               req_pop,
  output logic [MST_CNT-1:0] mrdy,
  output logic               req_valid,
  output logic [MST_CNT-1:0] req_mid,
  output logic [SLV_CNT-1:0] req_sid,
  output cab_bus_pkg::addr_t req_offset,
  output logic               req_wr,
  output cab_bus_pkg::data_t req_wdata
);

  localparam int Q_DEPTH = 8;
  localparam int Q_PTR_W = $clog2(Q_DEPTH);

  logic [SLV_CNT-1:0] dec_sid [MST_CNT];
  cab_bus_pkg::addr_t dec_offset [MST_CNT];
  logic [MST_CNT-1:0] q_empty;
  logic [SLV_CNT-1:0] head_sid [MST_CNT];
  cab_bus_pkg::addr_t head_offset [MST_CNT];
  logic [MST_CNT-1:0] head_wr;
  cab_bus_pkg::data_t head_wdata [MST_CNT];

  // window match and offset per master
  always_comb begin
    for (int m = 0; m < MST_CNT; m++) begin
      dec_sid[m] = '0;
      dec_offset[m] = '0;
      for (int s = 0; s < SLV_CNT; s++) begin
        if (int'(maddr[m]) >= s * cab_map_pkg::CAB_WINDOW &&
            int'(maddr[m]) < (s + 1) * cab_map_pkg::CAB_WINDOW) begin
          dec_sid[m][s] = 1'b1;
          dec_offset[m] = maddr[m] - cab_bus_pkg::addr_t'(s * cab_map_pkg::CAB_WINDOW);
        end
      end
    end
  end

  for (genvar m = 0; m < MST_CNT; m++) begin : g_mq
    logic [SLV_CNT-1:0] mem_sid [Q_DEPTH];
    cab_bus_pkg::addr_t mem_offset [Q_DEPTH];
    logic [Q_DEPTH-1:0] mem_wr;
    cab_bus_pkg::data_t mem_wdata [Q_DEPTH];
    logic [Q_PTR_W:0]   wptr;
    logic [Q_PTR_W:0]   rptr;
    logic               push;
    logic               pop;

    assign q_empty[m] = wptr == rptr;
    // extra pointer bit tells full from empty
    assign mrdy[m] = !((wptr[Q_PTR_W] != rptr[Q_PTR_W]) &&
                       (wptr[Q_PTR_W-1:0] == rptr[Q_PTR_W-1:0]));
    assign push = mreq[m] && mrdy[m];
    assign pop = req_pop && !q_empty[m];

    always_ff @(posedge clk) begin
      if (push) begin
        mem_sid[wptr[Q_PTR_W-1:0]] <= dec_sid[m];
        mem_offset[wptr[Q_PTR_W-1:0]] <= dec_offset[m];
        mem_wr[wptr[Q_PTR_W-1:0]] <= mwr[m];
        mem_wdata[wptr[Q_PTR_W-1:0]] <= mwdata[m];
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wptr <= '0;
        rptr <= '0;
      end else begin
        if (push) begin
          wptr <= wptr + 1'b1;
        end
        if (pop) begin
          rptr <= rptr + 1'b1;
        end
      end
    end

    assign head_sid[m] = mem_sid[rptr[Q_PTR_W-1:0]];
    assign head_offset[m] = mem_offset[rptr[Q_PTR_W-1:0]];
    assign head_wr[m] = mem_wr[rptr[Q_PTR_W-1:0]];
    assign head_wdata[m] = mem_wdata[rptr[Q_PTR_W-1:0]];
  end

  // masters are exclusive, so the non-empty set is already one-hot
  assign req_mid = ~q_empty;
  assign req_valid = |req_mid;

  always_comb begin
    req_sid = '0;
    req_offset = '0;
    req_wr = 1'b0;
    req_wdata = '0;
    for (int m = 0; m < MST_CNT; m++) begin
      if (req_mid[m]) begin
        req_sid = req_sid | head_sid[m];
        req_offset = req_offset | head_offset[m];
        req_wr = req_wr | head_wr[m];
        req_wdata = req_wdata | head_wdata[m];
      end
    end
  end

  a_one_master_queued: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(~q_empty)
  ) else $error("requests queued from more than one master");

endmodule

// File: source/cab_send_fsm.sv
`timescale 1ns/1ns

module cab_send_fsm #(
  parameter int MST_CNT = 2,
  parameter int SLV_CNT = 2,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid,
  input  logic [MST_CNT-1:0] req_mid,
  input  logic [SLV_CNT-1:0] req_sid,
  input  cab_bus_pkg::addr_t req_offset,
  input  logic               req_wr,
  input  cab_bus_pkg::data_t req_wdata,
  input  logic [SLV_CNT-1:0] srdy,
  input  logic               ent_rdy,
  output logic               req_pop,
  output logic [SLV_CNT-1:0] sreq,
  output cab_bus_pkg::half_t sreqdata [SLV_CNT],
  output logic               ent_push,
  output logic [MST_CNT-1:0] ent_mid,
  output logic [SLV_CNT-1:0] ent_sid,
  output logic               ent_done
);

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  cab_bus_pkg::send_state_t state;
  cab_bus_pkg::send_state_t state_nxt;
  cab_bus_pkg::sreq_word_u  word;
  logic                     slv_rdy;
  logic                     send;
  logic                     wait_slv;
  logic                     tx_timeout;
  logic [CNT_W-1:0]         tx_cnt;

  // zero when the address hit no window, so such a request only times out
  assign slv_rdy = |(srdy & req_sid);
  assign tx_timeout = tx_cnt == CNT_W'(TIMEOUT_CYCLES - 1);

  always_comb begin
    state_nxt = state;
    send = 1'b0;
    wait_slv = 1'b0;
    req_pop = 1'b0;
    ent_push = 1'b0;
    word = '0;
    case (state)
      cab_bus_pkg::send_addr: begin
        word.hdr.offset = req_offset[cab_map_pkg::HDR_OFS_LSB +: $bits(word.hdr.offset)];
        word.hdr.rsvd = 1'b0;
        word.hdr.wr = req_wr;
        if (req_valid && slv_rdy && ent_rdy) begin
          send = 1'b1;
          if (req_wr) begin
            state_nxt = cab_bus_pkg::send_wdata_lo;
          end else begin
            req_pop = 1'b1;
            ent_push = 1'b1;
          end
        end else if (req_valid && !slv_rdy) begin
          wait_slv = 1'b1;
          req_pop = tx_timeout;
        end
      end
      cab_bus_pkg::send_wdata_lo: begin
        word.data = req_wdata[15:0];
        if (slv_rdy) begin
          send = 1'b1;
          state_nxt = cab_bus_pkg::send_wdata_hi;
        end else begin
          wait_slv = 1'b1;
          if (tx_timeout) begin
            req_pop = 1'b1;
            state_nxt = cab_bus_pkg::send_addr;
          end
        end
      end
      cab_bus_pkg::send_wdata_hi: begin
        word.data = req_wdata[31:16];
        if (slv_rdy) begin
          // write is complete once the high half is out
          send = 1'b1;
          req_pop = 1'b1;
          ent_push = 1'b1;
          state_nxt = cab_bus_pkg::send_addr;
        end else begin
          wait_slv = 1'b1;
          if (tx_timeout) begin
            req_pop = 1'b1;
            state_nxt = cab_bus_pkg::send_addr;
          end
        end
      end
      default: begin
        state_nxt = cab_bus_pkg::send_addr;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cab_bus_pkg::send_addr;
    end else begin
      state <= state_nxt;
    end
  end

  // stall counter cleared by any progress
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_cnt <= '0;
    end else if (!wait_slv || req_pop) begin
      tx_cnt <= '0;
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign sreq = send ? req_sid : '0;

  for (genvar s = 0; s < SLV_CNT; s++) begin : g_sdata
    assign sreqdata[s] = sreq[s] ? word.data : '0;
  end

  assign ent_mid = req_mid;
  assign ent_sid = req_sid;
  // writes need no acknowledge data
  assign ent_done = req_wr;

  a_sreq_onehot: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(sreq)
  ) else $error("request word sent to more than one slave");

  a_sreq_rdy: assert property (
    @(posedge clk) disable iff (!rst_n) (sreq & ~srdy) == '0
  ) else $error("request word sent to a slave that is not ready");

endmodule

// File: source/cab_ack_buffer.sv
`timescale 1ns/1ns

module cab_ack_buffer #(
  parameter int MST_CNT = 2,
  parameter int SLV_CNT = 2,
  parameter int ACK_DEPTH = 8,
  parameter int TIMEOUT_CYCLES = 64
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ent_push,
  input  logic [MST_CNT-1:0] ent_mid,
  input  logic [SLV_CNT-1:0] ent_sid,
  input  logic               ent_done,
  input  logic [SLV_CNT-1:0] sack,
  input  cab_bus_pkg::half_t sackdata [SLV_CNT],
  output logic               ent_rdy,
  output logic [MST_CNT-1:0] mdn,
  output cab_bus_pkg::data_t mrdata [MST_CNT]
);

  localparam int PTR_W = (ACK_DEPTH > 1) ? $clog2(ACK_DEPTH) : 1;
  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

  logic [ACK_DEPTH-1:0] ent_vld;
  logic [ACK_DEPTH-1:0] ent_cmp;
  logic [ACK_DEPTH-1:0] ent_hsel;
  logic [MST_CNT-1:0]   ent_mid_q [ACK_DEPTH];
  logic [SLV_CNT-1:0]   ent_sid_q [ACK_DEPTH];
  cab_bus_pkg::data_t   ent_data [ACK_DEPTH];
  logic [PTR_W-1:0]     wptr;
  logic [PTR_W-1:0]     rptr;
  logic [SLV_CNT-1:0]   wb_hit;
  logic [PTR_W-1:0]     wb_idx [SLV_CNT];
  logic                 head_vld;
  logic                 head_pop;
  logic                 rx_timeout;
  logic [CNT_W-1:0]     rx_cnt;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(ACK_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // oldest incomplete entry per slave takes that slave's next half
  always_comb begin
    int idx;
    for (int s = 0; s < SLV_CNT; s++) begin
      wb_hit[s] = 1'b0;
      wb_idx[s] = '0;
      // walk from youngest to oldest so the oldest match wins
      for (int i = ACK_DEPTH - 1; i >= 0; i--) begin
        idx = int'(rptr) + i;
        if (idx >= ACK_DEPTH) begin
          idx = idx - ACK_DEPTH;
        end
        if (ent_vld[idx] && !ent_cmp[idx] && ent_sid_q[idx][s]) begin
          wb_hit[s] = 1'b1;
          wb_idx[s] = PTR_W'(idx);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_vld <= '0;
      ent_cmp <= '0;
      ent_hsel <= '0;
    end else begin
      if (head_pop) begin
        ent_vld[rptr] <= 1'b0;
      end
      if (ent_push) begin
        ent_vld[wptr] <= 1'b1;
        ent_cmp[wptr] <= ent_done;
        ent_hsel[wptr] <= 1'b0;
      end
      for (int s = 0; s < SLV_CNT; s++) begin
        if (sack[s] && wb_hit[s]) begin
          ent_hsel[wb_idx[s]] <= 1'b1;
          if (ent_hsel[wb_idx[s]]) begin
            ent_cmp[wb_idx[s]] <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ent_push) begin
      ent_mid_q[wptr] <= ent_mid;
      ent_sid_q[wptr] <= ent_sid;
      ent_data[wptr] <= '0;
    end
    for (int s = 0; s < SLV_CNT; s++) begin
      if (sack[s] && wb_hit[s]) begin
        if (ent_hsel[wb_idx[s]]) begin
          ent_data[wb_idx[s]][31:16] <= sackdata[s];
        end else begin
          ent_data[wb_idx[s]][15:0] <= sackdata[s];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (ent_push) begin
        wptr <= ptr_inc(wptr);
      end
      if (head_pop) begin
        rptr <= ptr_inc(rptr);
      end
    end
  end

  assign ent_rdy = !ent_vld[wptr];
  assign head_vld = ent_vld[rptr];

  // return timeout counts only while the head waits for data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt <= '0;
    end else if (!head_vld || ent_cmp[rptr] || head_pop) begin
      rx_cnt <= '0;
    end else begin
      rx_cnt <= rx_cnt + 1'b1;
    end
  end

  assign rx_timeout = head_vld && !ent_cmp[rptr] && rx_cnt == CNT_W'(TIMEOUT_CYCLES - 1);
  assign head_pop = head_vld && (ent_cmp[rptr] || rx_timeout);

  assign mdn = head_pop ? ent_mid_q[rptr] : '0;

  for (genvar m = 0; m < MST_CNT; m++) begin : g_mrdata
    assign mrdata[m] = ent_data[rptr];
  end

  a_push_when_free: assert property (
    @(posedge clk) disable iff (!rst_n) ent_push |-> ent_rdy
  ) else $error("entry pushed into a full acknowledge buffer");

endmodule

// File: source/cab_bridge.sv
`timescale 1ns/1ns

module cab_bridge #(
  parameter int MST_CNT = 2,
  parameter int SLV_CNT = 2,
  parameter int ACK_DEPTH = 8,
  parameter int TIMEOUT_CYCLES = cab_map_pkg::DEFAULT_TIMEOUT
) (
  input  logic               clk,
  input  logic               rst_n,
  input  cab_bus_pkg::addr_t maddr [MST_CNT],
  input  cab_bus_pkg::data_t mwdata [MST_CNT],
  input  logic [MST_CNT-1:0] mwr,
  input  logic [MST_CNT-1:0] mreq,
  output logic [MST_CNT-1:0] mrdy,
  output logic [MST_CNT-1:0] mdn,
  output cab_bus_pkg::data_t mrdata [MST_CNT],
  input  logic [SLV_CNT-1:0] srdy,
  input  logic [SLV_CNT-1:0] sack,
  input  cab_bus_pkg::half_t sackdata [SLV_CNT],
  output logic [SLV_CNT-1:0] sreq,
  output cab_bus_pkg::half_t sreqdata [SLV_CNT]
);

  logic               req_valid;
  logic [MST_CNT-1:0] req_mid;
  logic [SLV_CNT-1:0] req_sid;
  cab_bus_pkg::addr_t req_offset;
  logic               req_wr;
  cab_bus_pkg::data_t req_wdata;
  logic               req_pop;
  logic               ent_push;
  logic [MST_CNT-1:0] ent_mid;
  logic [SLV_CNT-1:0] ent_sid;
  logic               ent_done;
  logic               ent_rdy;

  cab_req_decode #(
    .MST_CNT (MST_CNT),
    .SLV_CNT (SLV_CNT)
  ) u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .maddr      (maddr),
    .mwdata     (mwdata),
    .mwr        (mwr),
    .mreq       (mreq),
    .req_pop    (req_pop),
    .mrdy       (mrdy),
    .req_valid  (req_valid),
    .req_mid    (req_mid),
    .req_sid    (req_sid),
    .req_offset (req_offset),
    .req_wr     (req_wr),
    .req_wdata  (req_wdata)
  );

  cab_send_fsm #(
    .MST_CNT        (MST_CNT),
    .SLV_CNT        (SLV_CNT),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_send (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_mid    (req_mid),
    .req_sid    (req_sid),
    .req_offset (req_offset),
    .req_wr     (req_wr),
    .req_wdata  (req_wdata),
    .srdy       (srdy),
    .ent_rdy    (ent_rdy),
    .req_pop    (req_pop),
    .sreq       (sreq),
    .sreqdata   (sreqdata),
    .ent_push   (ent_push),
    .ent_mid    (ent_mid),
    .ent_sid    (ent_sid),
    .ent_done   (ent_done)
  );

  cab_ack_buffer #(
    .MST_CNT        (MST_CNT),
    .SLV_CNT        (SLV_CNT),
    .ACK_DEPTH      (ACK_DEPTH),
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_ack (
    .clk      (clk),
    .rst_n    (rst_n),
    .ent_push (ent_push),
    .ent_mid  (ent_mid),
    .ent_sid  (ent_sid),
    .ent_done (ent_done),
    .sack     (sack),
    .sackdata (sackdata),
    .ent_rdy  (ent_rdy),
    .mdn      (mdn),
    .mrdata   (mrdata)
  );

endmodule

// File: testbench/cab_slave_model.sv
`timescale 1ns/1ns

module cab_slave_model (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mute,
  input  logic               sreq,
  input  cab_bus_pkg::half_t sreqdata,
  output logic               srdy,
  output logic               sack,
  output cab_bus_pkg::half_t sackdata,
  output int                 hdr_cnt
);

  cab_bus_pkg::data_t      mem [int];
  cab_bus_pkg::data_t      rd_q [$];
  cab_bus_pkg::sreq_word_u word;
  cab_bus_pkg::half_t      wr_lo;
  cab_bus_pkg::data_t      ack_word;
  int                      wr_phase;
  int                      wr_ofs;
  int                      delay;
  int                      ack_phase;

  // request words are settled by the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      wr_phase = 0;
      hdr_cnt = 0;
      rd_q.delete();
    end else if (sreq) begin
      word = sreqdata;
      case (wr_phase)
        0: begin
          hdr_cnt++;
          if (word.hdr.wr) begin
            wr_ofs = int'(word.hdr.offset);
            wr_phase = 1;
          end else if (!mute) begin
            rd_q.push_back(mem.exists(int'(word.hdr.offset)) ?
                           mem[int'(word.hdr.offset)] : '0);
          end
        end
        1: begin
          wr_lo = word.data;
          wr_phase = 2;
        end
        default: begin
          mem[wr_ofs] = {word.data, wr_lo};
          wr_phase = 0;
        end
      endcase
    end
  end

  initial begin
    srdy = 1'b0;
    sack = 1'b0;
    sackdata = '0;
    delay = -1;
    ack_phase = 0;
    forever begin
      @(posedge clk);
      #1;
      sack = 1'b0;
      sackdata = '0;
      if (!rst_n) begin
        srdy = 1'b0;
        delay = -1;
        ack_phase = 0;
      end else begin
        srdy = ($urandom_range(0, 3) != 0);
        if (ack_phase == 1) begin
          // high half right after the low half
          sack = 1'b1;
          sackdata = ack_word[31:16];
          ack_phase = 0;
        end else if (rd_q.size() != 0) begin
          if (delay < 0) begin
            delay = $urandom_range(1, 10);
          end
          delay--;
          if (delay == 0) begin
            ack_word = rd_q.pop_front();
            sack = 1'b1;
            sackdata = ack_word[15:0];
            ack_phase = 1;
            delay = -1;
          end
        end
      end
    end
  end

endmodule

// File: testbench/cab_tb.sv
`timescale 1ns/1ns

module cab_tb;

  localparam int MST = 2;
  localparam int SLV = 2;
  localparam int WIN = cab_map_pkg::CAB_WINDOW;
  // traffic needs roughly 800 cycles including the send timeouts
  localparam int MAX_CYCLES = 5000;

  logic               clk;
  logic               rst_n;
  cab_bus_pkg::addr_t maddr [MST];
  cab_bus_pkg::data_t mwdata [MST];
  logic [MST-1:0]     mwr;
  logic [MST-1:0]     mreq;
  logic [MST-1:0]     mrdy;
  logic [MST-1:0]     mdn;
  cab_bus_pkg::data_t mrdata [MST];
  logic [SLV-1:0]     srdy;
  logic [SLV-1:0]     sack;
  cab_bus_pkg::half_t sackdata [SLV];
  logic [SLV-1:0]     sreq;
  cab_bus_pkg::half_t sreqdata [SLV];
  logic [SLV-1:0]     mute;
  int                 hdr_cnt [SLV];

  // expected results in acceptance order
  int                 exp_mid_q [$];
  cab_bus_pkg::data_t exp_data_q [$];
  cab_bus_pkg::data_t ref_mem [int];
  int                 exp_hdr = 0;
  int                 cyc_cnt = 0;
  int                 post_rst;
  int                 e_mid;
  cab_bus_pkg::data_t e_data;

  cab_bridge #(
    .MST_CNT        (MST),
    .SLV_CNT        (SLV),
    .ACK_DEPTH      (8),
    .TIMEOUT_CYCLES (64)
  ) u_cab_bridge (
    .clk      (clk),
    .rst_n    (rst_n),
    .maddr    (maddr),
    .mwdata   (mwdata),
    .mwr      (mwr),
    .mreq     (mreq),
    .mrdy     (mrdy),
    .mdn      (mdn),
    .mrdata   (mrdata),
    .srdy     (srdy),
    .sack     (sack),
    .sackdata (sackdata),
    .sreq     (sreq),
    .sreqdata (sreqdata)
  );

  for (genvar s = 0; s < SLV; s++) begin : g_slv
    cab_slave_model u_slv (
      .clk      (clk),
      .rst_n    (rst_n),
      .mute     (mute[s]),
      .sreq     (sreq[s]),
      .sreqdata (sreqdata[s]),
      .srdy     (srdy[s]),
      .sack     (sack[s]),
      .sackdata (sackdata[s]),
      .hdr_cnt  (hdr_cnt[s])
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic mismatch_stop(input string msg);
    abort_run($sformatf("mismatch at %0t ns: %s", $time, msg));
  endtask

  function automatic cab_bus_pkg::data_t ref_read(input cab_bus_pkg::addr_t addr);
    return ref_mem.exists(int'(addr)) ? ref_mem[int'(addr)] : '0;
  endfunction

  // word aligned because the header carries only the word offset
  function automatic cab_bus_pkg::addr_t rand_addr(input int slv);
    return cab_bus_pkg::addr_t'(slv * WIN + 4 * $urandom_range(0, WIN / 4 - 1));
  endfunction

  // entered and left a little after a rising edge
  task automatic issue_req(input int mst, input logic wr, input cab_bus_pkg::addr_t addr,
                           input cab_bus_pkg::data_t wdata);
    int sidx;
    sidx = int'(addr) / WIN;
    mreq[mst] = 1'b1;
    mwr[mst] = wr;
    maddr[mst] = addr;
    mwdata[mst] = wdata;
    @(negedge clk);
    while (!mrdy[mst]) @(negedge clk);
    @(posedge clk);
    #1;
    mreq[mst] = 1'b0;
    if (sidx < SLV) begin
      exp_hdr++;
      exp_mid_q.push_back(mst);
      if (wr) begin
        ref_mem[int'(addr)] = wdata;
        exp_data_q.push_back('0);
      end else if (mute[sidx]) begin
        exp_data_q.push_back('0);
      end else begin
        exp_data_q.push_back(ref_read(addr));
      end
    end
  endtask

  task automatic drain_results();
    @(posedge clk);
    while (exp_mid_q.size() != 0) @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      post_rst <= 0;
    end else if (post_rst < 3) begin
      post_rst <= post_rst + 1;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n || post_rst < 3) begin
      assert (sreq == '0 && mdn == '0 && mrdy == '1)
        else abort_run("outputs not idle during or right after reset");
    end
    assert ($onehot0(sreq)) else abort_run("sreq raised to more than one slave");
    assert ((sreq & ~srdy) == '0) else abort_run("sreq raised to a slave that is not ready");
    assert ($onehot0(mdn)) else abort_run("mdn raised to more than one master");
    for (int m = 0; m < MST; m++) begin
      if (rst_n && mdn[m]) begin
        assert (exp_mid_q.size() != 0) else abort_run("mdn with no request outstanding");
        e_mid = exp_mid_q.pop_front();
        e_data = exp_data_q.pop_front();
        assert (e_mid == m)
          else mismatch_stop($sformatf("mdn to master %0d, expected master %0d", m, e_mid));
        assert (mrdata[m] == e_data)
          else mismatch_stop($sformatf("master %0d data %h, expected %h", m, mrdata[m], e_data));
      end
    end
  end

  initial begin
    int                 hdr_sum;
    cab_bus_pkg::addr_t a;
    cab_bus_pkg::addr_t wr_addr [$];
    void'($urandom(92));
    rst_n = 1'b0;
    mreq = '0;
    mwr = '0;
    mute = '0;
    for (int m = 0; m < MST; m++) begin
      maddr[m] = '0;
      mwdata[m] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;

    // write and read back at both ends of every window for each master
    for (int m = 0; m < MST; m++) begin
      for (int s = 0; s < SLV; s++) begin
        a = cab_bus_pkg::addr_t'(s * WIN + 'h10);
        issue_req(m, 1'b1, a, $urandom());
        issue_req(m, 1'b0, a, '0);
        a = cab_bus_pkg::addr_t'((s + 1) * WIN - 4);
        issue_req(m, 1'b1, a, $urandom());
        issue_req(m, 1'b0, a, '0);
      end
      drain_results();
    end

    // back to back reads alternating slaves over the words written above
    for (int i = 0; i < 16; i++) begin
      a = cab_bus_pkg::addr_t'((i % SLV) * WIN + (((i / SLV) % 2 == 0) ? 'h10 : WIN - 4));
      issue_req(1, 1'b0, a, '0);
    end
    drain_results();

    // random writes under random srdy, then read each one back
    for (int i = 0; i < 12; i++) begin
      a = rand_addr($urandom_range(0, SLV - 1));
      wr_addr.push_back(a);
      issue_req(0, 1'b1, a, $urandom());
    end
    foreach (wr_addr[i]) begin
      issue_req(0, 1'b0, wr_addr[i], '0);
    end
    drain_results();

    // unmapped addresses are dropped
    issue_req(0, 1'b1, 16'h2000, 32'hdead_beef);
    issue_req(0, 1'b0, 16'hf004, '0);
    issue_req(0, 1'b0, wr_addr[0], '0);
    drain_results();

    // muted slave 1 returns zero and later results stay in order
    mute[1] = 1'b1;
    issue_req(1, 1'b0, cab_bus_pkg::addr_t'(WIN + 'h10), '0);
    issue_req(1, 1'b0, cab_bus_pkg::addr_t'('h10), '0);
    issue_req(1, 1'b0, cab_bus_pkg::addr_t'(WIN - 4), '0);
    issue_req(1, 1'b0, rand_addr(0), '0);
    drain_results();
    mute[1] = 1'b0;
    issue_req(1, 1'b0, cab_bus_pkg::addr_t'(WIN + 'h10), '0);
    drain_results();

    hdr_sum = 0;
    for (int s = 0; s < SLV; s++) begin
      hdr_sum += hdr_cnt[s];
    end
    assert (hdr_sum == exp_hdr) begin
      $display("Everything OK");
      $finish;
    end else begin
      mismatch_stop($sformatf("%0d headers at the slaves, expected %0d", hdr_sum, exp_hdr));
    end
  end

endmodule

// File: verilog.f
source/cab_bus_pkg.sv
source/cab_map_pkg.sv
source/cab_req_decode.sv
source/cab_send_fsm.sv
source/cab_ack_buffer.sv
source/cab_bridge.sv
testbench/cab_slave_model.sv
testbench/cab_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the CAB bridge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cab_tb -f verilog.f \
  && ./obj_dir/Vcab_tb | tee /dev/stderr | grep -q "^Everything OK$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
